//--- hdl/commit_monitor_top.sv
`timescale 1ns/100ps

module commit_monitor_top (
    input  logic                    clk,
    input  logic                    rst,
    // decode and commit side
    input  logic [trace_pkg::DEC_WIDTH-1:0] dec_valid,
    input  trace_pkg::opid_t        dec_opid [trace_pkg::DEC_WIDTH-1:0],
    input  trace_pkg::xlen_t        csr_mstatus,
    input  trace_pkg::xlen_t        csr_mtvec,
    input  trace_pkg::xlen_t        csr_mcause,
    input  trace_pkg::xlen_t        csr_mepc,
    input  trace_pkg::opid_t        cmt_opid,
    // csr unit probes
    input  logic                    csr_we,
    input  logic                    csr_rqst,
    input  logic                    csr_eout,
    input  trace_pkg::csr_addr_t    csr_addr,
    input  trace_pkg::xlen_t        csr_wres,
    input  trace_pkg::xlen_t        csr_mcycle,
    input  trace_pkg::xlen_t        csr_minstret,
    // dcache probes
    input  trace_pkg::dc_tag_t      dc_rqst,
    input  trace_pkg::dc_tag_t      dc_resp,
    input  trace_pkg::xlen_t        dc_addr,
    input  trace_pkg::xlen_t        dc_wdat,
    input  trace_pkg::strb_t        dc_strb,
    input  logic                    dc_miss,
    // redirect probes
    input  logic                    be_redir,
    input  logic                    redir_branch,
    input  logic                    redir_jal,
    input  logic                    redir_jalr,
    input  logic                    fe_redir,
    // trace outputs
    output trace_pkg::xlen_t        cmt_mstatus,
    output trace_pkg::xlen_t        cmt_mtvec,
    output trace_pkg::xlen_t        cmt_mcause,
    output trace_pkg::xlen_t        cmt_mepc,
    output logic                    del_csrw,
    output trace_pkg::csr_addr_t    del_csra,
    output trace_pkg::xlen_t        del_csrv,
    output trace_pkg::xlen_t        cmt_mcycle,
    output trace_pkg::xlen_t        cmt_minstret,
    output trace_pkg::mem_size_t    del_memw,
    output trace_pkg::xlen_t        del_mema,
    output trace_pkg::xlen_t        del_memv,
    // stats
    output trace_pkg::counter_t     loads,
    output trace_pkg::counter_t     stores,
    output trace_pkg::counter_t     bmisp,
    output trace_pkg::counter_t     brmisp,
    output trace_pkg::counter_t     jmisp,
    output trace_pkg::counter_t     jrmisp,
    output trace_pkg::counter_t     fmisp
);

    csr_snapshot snap_inst (
        .clk(clk), .dec_valid(dec_valid), .dec_opid(dec_opid),
        .csr_mstatus(csr_mstatus), .csr_mtvec(csr_mtvec),
        .csr_mcause(csr_mcause), .csr_mepc(csr_mepc), .cmt_opid(cmt_opid),
        .cmt_mstatus(cmt_mstatus), .cmt_mtvec(cmt_mtvec),
        .cmt_mcause(cmt_mcause), .cmt_mepc(cmt_mepc)
    );

    csr_write_trace csrw_inst (
        .clk(clk), .rst(rst), .csr_we(csr_we), .csr_rqst(csr_rqst),
        .csr_eout(csr_eout), .csr_addr(csr_addr), .csr_wres(csr_wres),
        .csr_mcycle(csr_mcycle), .csr_minstret(csr_minstret),
        .del_csrw(del_csrw), .del_csra(del_csra), .del_csrv(del_csrv),
        .cmt_mcycle(cmt_mcycle), .cmt_minstret(cmt_minstret)
    );

    store_trace st_inst (
        .clk(clk), .dc_rqst(dc_rqst), .dc_resp(dc_resp), .dc_addr(dc_addr),
        .dc_wdat(dc_wdat), .dc_strb(dc_strb), .dc_miss(dc_miss),
        .del_memw(del_memw), .del_mema(del_mema), .del_memv(del_memv)
    );

    perf_counters perf_inst (
        .clk(clk), .rst(rst), .dc_rqst(dc_rqst), .dc_strb(dc_strb),
        .be_redir(be_redir), .redir_branch(redir_branch), .redir_jal(redir_jal),
        .redir_jalr(redir_jalr), .fe_redir(fe_redir),
        .loads(loads), .stores(stores), .bmisp(bmisp), .brmisp(brmisp),
        .jmisp(jmisp), .jrmisp(jrmisp), .fmisp(fmisp)
    );

endmodule

//--- hdl/csr_snapshot.sv
`timescale 1ns/100ps

module csr_snapshot (
    input  logic                            clk,
    input  logic [trace_pkg::DEC_WIDTH-1:0] dec_valid,
    input  trace_pkg::opid_t                dec_opid [trace_pkg::DEC_WIDTH-1:0],
    input  trace_pkg::xlen_t                csr_mstatus,
    input  trace_pkg::xlen_t                csr_mtvec,
    input  trace_pkg::xlen_t                csr_mcause,
    input  trace_pkg::xlen_t                csr_mepc,
    input  trace_pkg::opid_t                cmt_opid,
    output trace_pkg::xlen_t                cmt_mstatus,
    output trace_pkg::xlen_t                cmt_mtvec,
    output trace_pkg::xlen_t                cmt_mcause,
    output trace_pkg::xlen_t                cmt_mepc
);

    // one entry per in-flight op, indexed by opid
    trace_pkg::xlen_t snap_mstatus [trace_pkg::OPID_DEPTH];
    trace_pkg::xlen_t snap_mtvec   [trace_pkg::OPID_DEPTH];
    trace_pkg::xlen_t snap_mcause  [trace_pkg::OPID_DEPTH];
    trace_pkg::xlen_t snap_mepc    [trace_pkg::OPID_DEPTH];

    // state seen by an op at decode is the state before it commits
    always_ff @(posedge clk) begin
        for (int i = 0; i < trace_pkg::DEC_WIDTH; i++) begin // later lane overrides
            if (dec_valid[i]) begin
                snap_mstatus[dec_opid[i]] <= csr_mstatus;
                snap_mtvec[dec_opid[i]]   <= csr_mtvec;
                snap_mcause[dec_opid[i]]  <= csr_mcause;
                snap_mepc[dec_opid[i]]    <= csr_mepc;
            end
        end
    end

    // commit head read
    assign cmt_mstatus = snap_mstatus[cmt_opid];
    assign cmt_mtvec   = snap_mtvec[cmt_opid];
    assign cmt_mcause  = snap_mcause[cmt_opid];
    assign cmt_mepc    = snap_mepc[cmt_opid];

endmodule

//--- hdl/csr_write_trace.sv
`timescale 1ns/100ps

module csr_write_trace (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 csr_we,
    input  logic                 csr_rqst,
    input  logic                 csr_eout,     // op raised an exception
    input  trace_pkg::csr_addr_t csr_addr,
    input  trace_pkg::xlen_t     csr_wres,
    input  trace_pkg::xlen_t     csr_mcycle,
    input  trace_pkg::xlen_t     csr_minstret,
    output logic                 del_csrw,
    output trace_pkg::csr_addr_t del_csra,
    output trace_pkg::xlen_t     del_csrv,
    output trace_pkg::xlen_t     cmt_mcycle,
    output trace_pkg::xlen_t     cmt_minstret
);

    logic is_smode;
    logic is_ucounter;
    logic hit_mcycle;
    logic hit_minstret;

    assign is_smode = csr_addr == trace_pkg::CSR_SSTATUS ||
                      csr_addr == trace_pkg::CSR_SIE     ||
                      csr_addr == trace_pkg::CSR_SIP;

    assign is_ucounter = csr_addr == trace_pkg::CSR_CYCLE ||
                         csr_addr == trace_pkg::CSR_TIME  ||
                         csr_addr == trace_pkg::CSR_INSTRET;

    // write record uses canonical machine addresses
    always_comb begin
        if (is_smode)
            del_csra = csr_addr + trace_pkg::SMODE_ALIAS_OFS;
        else if (is_ucounter)
            del_csra = csr_addr - trace_pkg::UCOUNTER_ALIAS_OFS;
        else
            del_csra = csr_addr;
    end

    assign del_csrw = csr_we;
    assign del_csrv = csr_wres;

    assign hit_mcycle   = csr_rqst && (csr_addr == trace_pkg::CSR_MCYCLE ||
                                       csr_addr == trace_pkg::CSR_CYCLE);
    assign hit_minstret = csr_rqst && (csr_addr == trace_pkg::CSR_MINSTRET ||
                                       csr_addr == trace_pkg::CSR_INSTRET);

    // counter value the op actually saw
    always_ff @(posedge clk) begin
        if (rst) begin
            cmt_mcycle <= '0;
        end else if (hit_mcycle) begin
            cmt_mcycle <= csr_eout ? csr_mcycle : csr_wres;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmt_minstret <= '0;
        end else if (hit_minstret) begin
            cmt_minstret <= csr_eout ? csr_minstret : csr_wres;
        end
    end

endmodule

//--- hdl/perf_counters.sv
`timescale 1ns/100ps

module perf_counters (
    input  logic                clk,
    input  logic                rst,
    input  trace_pkg::dc_tag_t  dc_rqst,
    input  trace_pkg::strb_t    dc_strb,
    input  logic                be_redir,     // back-end misprediction
    input  logic                redir_branch,
    input  logic                redir_jal,
    input  logic                redir_jalr,
    input  logic                fe_redir,     // front-end misprediction
    output trace_pkg::counter_t loads,
    output trace_pkg::counter_t stores,
    output trace_pkg::counter_t bmisp,
    output trace_pkg::counter_t brmisp,
    output trace_pkg::counter_t jmisp,
    output trace_pkg::counter_t jrmisp,
    output trace_pkg::counter_t fmisp
);

    localparam int NUM_CNT = 7;

    logic [NUM_CNT-1:0]  evt;
    trace_pkg::counter_t cnt [NUM_CNT];

    // events in the same order as the outputs
    assign evt[0] = |dc_rqst && ~|dc_strb;      // load
    assign evt[1] = |dc_rqst &&  |dc_strb;      // store
    assign evt[2] = be_redir;
    assign evt[3] = be_redir && redir_branch;
    assign evt[4] = be_redir && redir_jal;
    assign evt[5] = be_redir && redir_jalr;
    assign evt[6] = fe_redir && !be_redir;      // back-end redirect takes precedence

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (rst)
                cnt[i] <= '0;
            else if (evt[i])
                cnt[i] <= cnt[i] + 64'd1;
        end
    end

    assign loads  = cnt[0];
    assign stores = cnt[1];
    assign bmisp  = cnt[2];
    assign brmisp = cnt[3];
    assign jmisp  = cnt[4];
    assign jrmisp = cnt[5];
    assign fmisp  = cnt[6];

endmodule

//--- hdl/store_trace.sv
`timescale 1ns/100ps

module store_trace (
    input  logic                 clk,
    input  trace_pkg::dc_tag_t   dc_rqst,
    input  trace_pkg::dc_tag_t   dc_resp,
    input  trace_pkg::xlen_t     dc_addr,
    input  trace_pkg::xlen_t     dc_wdat,
    input  trace_pkg::strb_t     dc_strb,
    input  logic                 dc_miss,
    output trace_pkg::mem_size_t del_memw,
    output trace_pkg::xlen_t     del_mema,
    output trace_pkg::xlen_t     del_memv
);

    // per-slot store record
    trace_pkg::xlen_t     st_addr [trace_pkg::ST_SLOTS];
    trace_pkg::xlen_t     st_data [trace_pkg::ST_SLOTS];
    trace_pkg::mem_size_t st_size [trace_pkg::ST_SLOTS];

    trace_pkg::st_idx_t   rqst_slot;
    trace_pkg::st_idx_t   resp_slot;
    logic                 rqst_store;
    logic                 resp_store;
    logic [2:0]           lo_byte;   // lowest strobed byte
    trace_pkg::mem_size_t strb_cnt;

    assign rqst_slot  = dc_rqst[trace_pkg::ST_IDX_W-1:0];
    assign resp_slot  = dc_resp[trace_pkg::ST_IDX_W-1:0];
    assign rqst_store = dc_rqst[7:4] == trace_pkg::STORE_TAG_MARK;
    assign resp_store = dc_resp[7:4] == trace_pkg::STORE_TAG_MARK;

    always_comb begin
        lo_byte = '0;
        for (int i = 7; i >= 0; i--) begin // last hit is the lowest
            if (dc_strb[i])
                lo_byte = 3'(i);
        end
    end

    always_comb begin
        strb_cnt = '0;
        for (int i = 0; i < 8; i++) begin
            if (dc_strb[i])
                strb_cnt = strb_cnt + 4'd1;
        end
    end

    // data stored right-aligned to the first written byte
    always_ff @(posedge clk) begin
        if (rqst_store) begin
            st_addr[rqst_slot] <= dc_addr;
            st_data[rqst_slot] <= dc_wdat >> {lo_byte, 3'b000};
            st_size[rqst_slot] <= strb_cnt;
        end
    end

    // memory change only on a store hit
    assign del_memw = (resp_store && !dc_miss) ? st_size[resp_slot] : '0;
    assign del_mema = st_addr[resp_slot];
    assign del_memv = st_data[resp_slot];

endmodule

//--- hdl/trace_pkg.sv
package trace_pkg;

    typedef logic [63:0] xlen_t;     // data or address word
    typedef logic [11:0] csr_addr_t;
    typedef logic  [6:0] opid_t;     // snapshot table index
    typedef logic  [7:0] dc_tag_t;   // dcache request/response tag
    typedef logic  [7:0] strb_t;     // byte strobe
    typedef logic  [3:0] mem_size_t; // bytes changed by a store
    typedef logic [63:0] counter_t;

    localparam int DEC_WIDTH  = 4;   // decode lanes
    localparam int OPID_DEPTH = 128;
    localparam int ST_SLOTS   = 8;
    localparam int ST_IDX_W   = $clog2(ST_SLOTS);

    typedef logic [ST_IDX_W-1:0] st_idx_t;

    // upper tag nibble of a tracked store
    localparam logic [3:0] STORE_TAG_MARK = 4'b1111;

    // supervisor views of machine CSRs
    localparam csr_addr_t CSR_SSTATUS = 12'h100;
    localparam csr_addr_t CSR_SIE     = 12'h104;
    localparam csr_addr_t CSR_SIP     = 12'h144;

    localparam csr_addr_t SMODE_ALIAS_OFS = 12'h200; // s-mode -> m-mode

    // user read-only counters
    localparam csr_addr_t CSR_CYCLE   = 12'hc00;
    localparam csr_addr_t CSR_TIME    = 12'hc01;
    localparam csr_addr_t CSR_INSTRET = 12'hc02;

    localparam csr_addr_t UCOUNTER_ALIAS_OFS = 12'h100; // user -> machine counter

    localparam csr_addr_t CSR_MCYCLE   = 12'hb00;
    localparam csr_addr_t CSR_MINSTRET = 12'hb02;

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the commit monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module commit_monitor_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcommit_monitor_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- src.f
hdl/trace_pkg.sv
hdl/csr_snapshot.sv
hdl/csr_write_trace.sv
hdl/store_trace.sv
hdl/perf_counters.sv
hdl/commit_monitor_top.sv
verif/commit_monitor_asserts.sv
verif/commit_monitor_tb.sv

//--- verif/commit_monitor_asserts.sv
`timescale 1ns/100ps

module commit_monitor_asserts (
    input logic                 clk,
    input logic                 rst,
    input trace_pkg::dc_tag_t   dc_resp,
    input logic                 dc_miss,
    input trace_pkg::mem_size_t del_memw,
    input trace_pkg::counter_t  loads,
    input trace_pkg::counter_t  stores
);

    // memory change only on a tracked store hit
    memw_on_store_hit: assert property (@(posedge clk) disable iff (rst)
        del_memw != '0 |-> (dc_resp[7:4] == trace_pkg::STORE_TAG_MARK && !dc_miss))
        else $error("del_memw nonzero without a store hit response");

    memw_max_bytes: assert property (@(posedge clk) disable iff (rst)
        del_memw <= 4'd8)
        else $error("del_memw above 8 bytes");

    loads_monotonic: assert property (@(posedge clk) disable iff (rst)
        loads >= $past(loads))
        else $error("load counter decreased");

    stores_monotonic: assert property (@(posedge clk) disable iff (rst)
        stores >= $past(stores))
        else $error("store counter decreased");

endmodule

bind commit_monitor_top commit_monitor_asserts asserts_inst (
    .clk(clk),
    .rst(rst),
    .dc_resp(dc_resp),
    .dc_miss(dc_miss),
    .del_memw(del_memw),
    .loads(loads),
    .stores(stores)
);

//--- verif/commit_monitor_tb.sv
`timescale 1ns/100ps

module commit_monitor_tb;

    localparam int CLK_HALF   = 4;
    localparam int WAIT_LIMIT = 20;

    // check groups for the compare process
    localparam int CHK_MEM  = 0;
    localparam int CHK_CSRW = 1;
    localparam int CHK_CAP  = 2;
    localparam int CHK_SNAP = 3;
    localparam int CHK_PERF = 4;

    logic clk;
    logic rst;
    logic [trace_pkg::DEC_WIDTH-1:0] dec_valid;
    trace_pkg::opid_t     dec_opid [trace_pkg::DEC_WIDTH-1:0];
    trace_pkg::xlen_t     csr_mstatus, csr_mtvec, csr_mcause, csr_mepc;
    trace_pkg::opid_t     cmt_opid;
    logic                 csr_we, csr_rqst, csr_eout;
    trace_pkg::csr_addr_t csr_addr;
    trace_pkg::xlen_t     csr_wres, csr_mcycle, csr_minstret;
    trace_pkg::dc_tag_t   dc_rqst, dc_resp;
    trace_pkg::xlen_t     dc_addr, dc_wdat;
    trace_pkg::strb_t     dc_strb;
    logic                 dc_miss;
    logic                 be_redir, redir_branch, redir_jal, redir_jalr, fe_redir;

    trace_pkg::xlen_t     cmt_mstatus, cmt_mtvec, cmt_mcause, cmt_mepc;
    logic                 del_csrw;
    trace_pkg::csr_addr_t del_csra;
    trace_pkg::xlen_t     del_csrv, cmt_mcycle, cmt_minstret;
    trace_pkg::mem_size_t del_memw;
    trace_pkg::xlen_t     del_mema, del_memv;
    trace_pkg::counter_t  loads, stores, bmisp, brmisp, jmisp, jrmisp, fmisp;

    // expected values posted by the stimulus
    logic [4:0]           chk_mask;
    int                   req_seq;
    int                   done_seq;
    trace_pkg::mem_size_t exp_memw;
    trace_pkg::xlen_t     exp_mema, exp_memv;
    logic                 exp_csrw;
    trace_pkg::csr_addr_t exp_csra;
    trace_pkg::xlen_t     exp_csrv, exp_mcycle, exp_minstret;
    trace_pkg::xlen_t     exp_snap [4];
    trace_pkg::counter_t  exp_cnt [7];

    // reference model state
    trace_pkg::xlen_t     ref_st_addr [trace_pkg::ST_SLOTS];
    trace_pkg::xlen_t     ref_st_data [trace_pkg::ST_SLOTS];
    trace_pkg::mem_size_t ref_st_size [trace_pkg::ST_SLOTS];
    trace_pkg::xlen_t     ref_snap [trace_pkg::OPID_DEPTH][4];
    trace_pkg::xlen_t     ref_mcycle, ref_minstret;
    trace_pkg::counter_t  ref_cnt [7];

    int errors;
    int checks;
    int tests_run;
    int test_err_base;

    commit_monitor_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic trace_pkg::csr_addr_t alias_csr(trace_pkg::csr_addr_t a);
        case (a)
            trace_pkg::CSR_SSTATUS, trace_pkg::CSR_SIE, trace_pkg::CSR_SIP:
                return a + trace_pkg::SMODE_ALIAS_OFS;
            trace_pkg::CSR_CYCLE, trace_pkg::CSR_TIME, trace_pkg::CSR_INSTRET:
                return a - trace_pkg::UCOUNTER_ALIAS_OFS;
            default:
                return a;
        endcase
    endfunction

    function automatic trace_pkg::mem_size_t store_size(trace_pkg::strb_t strb);
        trace_pkg::mem_size_t n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            if (strb[i])
                n = n + 4'd1;
        end
        return n;
    endfunction

    // data moved down to the first written byte
    function automatic trace_pkg::xlen_t store_align(trace_pkg::xlen_t d, trace_pkg::strb_t s);
        for (int i = 0; i < 8; i++) begin
            if (s[i])
                return d >> (8 * i);
        end
        return d;
    endfunction

    // counter increments in output order from loads to fmisp
    function automatic logic [6:0] perf_events(trace_pkg::dc_tag_t rq, trace_pkg::strb_t st,
                                               logic be, logic br, logic jal, logic jalr,
                                               logic fe);
        logic [6:0] ev;
        ev[0] = (rq != '0) && (st == '0);
        ev[1] = (rq != '0) && (st != '0);
        ev[2] = be;
        ev[3] = be && br;
        ev[4] = be && jal;
        ev[5] = be && jalr;
        ev[6] = fe && !be;
        return ev;
    endfunction

    task automatic report_mismatch(string name, logic [63:0] exp_val, logic [63:0] got_val);
        errors++;
        $display("ERROR t=%0t %s expected=%h got=%h", $time, name, exp_val, got_val);
    endtask

    task automatic compare_outputs();
        trace_pkg::counter_t got_cnt [7];
        string cnt_name [7] = '{"loads", "stores", "bmisp", "brmisp", "jmisp", "jrmisp", "fmisp"};
        got_cnt = '{loads, stores, bmisp, brmisp, jmisp, jrmisp, fmisp};
        checks++;
        if (chk_mask[CHK_MEM]) begin
            if (del_memw !== exp_memw)
                report_mismatch("del_memw", 64'(exp_memw), 64'(del_memw));
            if (exp_memw != '0 && del_mema !== exp_mema)
                report_mismatch("del_mema", exp_mema, del_mema);
            if (exp_memw != '0 && del_memv !== exp_memv)
                report_mismatch("del_memv", exp_memv, del_memv);
        end
        if (chk_mask[CHK_CSRW]) begin
            if (del_csrw !== exp_csrw)
                report_mismatch("del_csrw", 64'(exp_csrw), 64'(del_csrw));
            if (del_csra !== exp_csra)
                report_mismatch("del_csra", 64'(exp_csra), 64'(del_csra));
            if (del_csrv !== exp_csrv)
                report_mismatch("del_csrv", exp_csrv, del_csrv);
        end
        if (chk_mask[CHK_CAP]) begin
            if (cmt_mcycle !== exp_mcycle)
                report_mismatch("cmt_mcycle", exp_mcycle, cmt_mcycle);
            if (cmt_minstret !== exp_minstret)
                report_mismatch("cmt_minstret", exp_minstret, cmt_minstret);
        end
        if (chk_mask[CHK_SNAP]) begin
            if (cmt_mstatus !== exp_snap[0])
                report_mismatch("cmt_mstatus", exp_snap[0], cmt_mstatus);
            if (cmt_mtvec !== exp_snap[1])
                report_mismatch("cmt_mtvec", exp_snap[1], cmt_mtvec);
            if (cmt_mcause !== exp_snap[2])
                report_mismatch("cmt_mcause", exp_snap[2], cmt_mcause);
            if (cmt_mepc !== exp_snap[3])
                report_mismatch("cmt_mepc", exp_snap[3], cmt_mepc);
        end
        if (chk_mask[CHK_PERF]) begin
            for (int i = 0; i < 7; i++) begin
                if (got_cnt[i] !== exp_cnt[i])
                    report_mismatch(cnt_name[i], exp_cnt[i], got_cnt[i]);
            end
        end
    endtask

    // sample one step after the rising edge
    always begin
        @(posedge clk);
        #1;
        if (done_seq != req_seq) begin
            compare_outputs();
            done_seq = req_seq;
        end
    end

    task automatic set_idle();
        dec_valid    = '0;
        csr_we       = 1'b0;
        csr_rqst     = 1'b0;
        csr_eout     = 1'b0;
        dc_rqst      = '0;
        dc_resp      = '0;
        dc_strb      = '0;
        dc_miss      = 1'b0;
        be_redir     = 1'b0;
        redir_branch = 1'b0;
        redir_jal    = 1'b0;
        redir_jalr   = 1'b0;
        fe_redir     = 1'b0;
    endtask

    // next falling edge once the compare process has caught up
    task automatic next_drive_edge();
        int n;
        n = 0;
        @(negedge clk);
        while (done_seq != req_seq && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done_seq != req_seq) begin
            $display("timeout: compare process did not run by %0t", $time);
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            chk_mask = '0;
            set_idle();
        end
    endtask

    task automatic post_check(int group);
        chk_mask[group] = 1'b1;
        req_seq++;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic end_test(string name);
        next_drive_edge();
        tests_run++;
        if (errors == test_err_base)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - test_err_base);
        test_err_base = errors;
    endtask

    task automatic test_store_trace();
        int pend [$];
        int slot;
        int idx;
        logic written [trace_pkg::ST_SLOTS];
        foreach (written[i])
            written[i] = 1'b0;
        for (int n = 0; n < 12; n++) begin
            next_drive_edge();
            slot    = $urandom_range(trace_pkg::ST_SLOTS - 1, 0);
            dc_rqst = {trace_pkg::STORE_TAG_MARK,
                       4'(slot + trace_pkg::ST_SLOTS * $urandom_range(1, 0))};
            dc_addr = {$urandom, $urandom};
            dc_wdat = {$urandom, $urandom};
            dc_strb = 8'($urandom_range(255, 1));
            ref_st_addr[slot] = dc_addr;
            ref_st_data[slot] = store_align(dc_wdat, dc_strb);
            ref_st_size[slot] = store_size(dc_strb);
            if (!written[slot])
                pend.push_back(slot);
            written[slot] = 1'b1;
        end
        while (pend.size() > 0) begin // hit responses in random order
            next_drive_edge();
            idx  = $urandom_range(pend.size() - 1, 0);
            slot = pend[idx];
            pend.delete(idx);
            dc_resp  = {trace_pkg::STORE_TAG_MARK,
                        4'(slot + trace_pkg::ST_SLOTS * $urandom_range(1, 0))};
            exp_memw = ref_st_size[slot];
            exp_mema = ref_st_addr[slot];
            exp_memv = ref_st_data[slot];
            post_check(CHK_MEM);
        end
        end_test("store trace");
    endtask

    task automatic test_non_store_resp();
        for (int n = 0; n < 16; n++) begin
            next_drive_edge();
            if ($urandom_range(1, 0) == 1) begin
                dc_resp = {trace_pkg::STORE_TAG_MARK, 4'($urandom)};
                dc_miss = 1'b1;
            end else begin
                dc_resp = {4'($urandom_range(14, 0)), 4'($urandom)}; // no store mark
                dc_miss = 1'($urandom);
            end
            exp_memw = '0;
            post_check(CHK_MEM);
        end
        end_test("miss and non-store response");
    endtask

    task automatic test_csr_alias();
        trace_pkg::csr_addr_t fixed [6];
        fixed = '{trace_pkg::CSR_SSTATUS, trace_pkg::CSR_SIE, trace_pkg::CSR_SIP,
                  trace_pkg::CSR_CYCLE, trace_pkg::CSR_TIME, trace_pkg::CSR_INSTRET};
        for (int n = 0; n < 30; n++) begin
            next_drive_edge();
            csr_we   = (n < 6) ? 1'b1 : 1'($urandom);
            csr_addr = (n < 6) ? fixed[n] : 12'($urandom);
            csr_wres = {$urandom, $urandom};
            exp_csrw = csr_we;
            exp_csra = alias_csr(csr_addr);
            exp_csrv = csr_wres;
            post_check(CHK_CSRW);
        end
        end_test("csr aliasing");
    endtask

    task automatic test_counter_capture();
        trace_pkg::csr_addr_t addrs [5];
        addrs = '{12'h300, trace_pkg::CSR_MCYCLE, trace_pkg::CSR_CYCLE,
                  trace_pkg::CSR_MINSTRET, trace_pkg::CSR_INSTRET};
        for (int n = 0; n < 20; n++) begin
            next_drive_edge();
            csr_rqst     = 1'b1;
            csr_addr     = (n < 10) ? addrs[n % 5] : addrs[$urandom_range(4, 0)];
            csr_eout     = (n < 10) ? 1'(n / 5) : 1'($urandom);
            csr_wres     = {$urandom, $urandom};
            csr_mcycle   = {$urandom, $urandom};
            csr_minstret = {$urandom, $urandom};
            if (csr_addr == trace_pkg::CSR_MCYCLE || csr_addr == trace_pkg::CSR_CYCLE)
                ref_mcycle = csr_eout ? csr_mcycle : csr_wres;
            if (csr_addr == trace_pkg::CSR_MINSTRET || csr_addr == trace_pkg::CSR_INSTRET)
                ref_minstret = csr_eout ? csr_minstret : csr_wres;
            exp_mcycle   = ref_mcycle;
            exp_minstret = ref_minstret;
            post_check(CHK_CAP);
        end
        end_test("counter capture");
    endtask

    task automatic test_snapshot();
        int ids [$];
        int idx;
        for (int r = 0; r < 6; r++) begin
            for (int d = 0; d < 3; d++) begin
                next_drive_edge();
                dec_valid   = 4'($urandom_range(15, 1));
                csr_mstatus = {$urandom, $urandom};
                csr_mtvec   = {$urandom, $urandom};
                csr_mcause  = {$urandom, $urandom};
                csr_mepc    = {$urandom, $urandom};
                for (int l = 0; l < trace_pkg::DEC_WIDTH; l++)
                    dec_opid[l] = trace_pkg::opid_t'($urandom);
                if ($urandom_range(3, 0) == 0)
                    dec_opid[trace_pkg::DEC_WIDTH-1] = dec_opid[0]; // lane clash
                for (int l = 0; l < trace_pkg::DEC_WIDTH; l++) begin // higher lane last
                    if (dec_valid[l]) begin
                        ref_snap[dec_opid[l]] = '{csr_mstatus, csr_mtvec, csr_mcause, csr_mepc};
                        ids.push_back(int'(dec_opid[l]));
                    end
                end
            end
            while (ids.size() > 0) begin
                next_drive_edge();
                idx      = $urandom_range(ids.size() - 1, 0);
                cmt_opid = trace_pkg::opid_t'(ids[idx]);
                ids.delete(idx);
                exp_snap = ref_snap[cmt_opid];
                post_check(CHK_SNAP);
            end
        end
        end_test("csr snapshot");
    endtask

    task automatic test_perf_counters();
        logic [6:0] ev;
        apply_reset();
        foreach (ref_cnt[i])
            ref_cnt[i] = '0;
        for (int n = 0; n < 80; n++) begin
            next_drive_edge();
            if ($urandom_range(1, 0) == 1)
                dc_rqst = 8'($urandom_range(255, 1));
            if ($urandom_range(1, 0) == 1)
                dc_strb = 8'($urandom_range(255, 1));
            be_redir     = $urandom_range(2, 0) == 0;
            redir_branch = 1'($urandom);
            redir_jal    = 1'($urandom);
            redir_jalr   = 1'($urandom);
            fe_redir     = $urandom_range(2, 0) == 0;
            ev = perf_events(dc_rqst, dc_strb, be_redir, redir_branch, redir_jal,
                             redir_jalr, fe_redir);
            for (int i = 0; i < 7; i++) begin
                if (ev[i])
                    ref_cnt[i]++;
            end
        end
        next_drive_edge(); // idle cycle lets the last events settle
        exp_cnt = ref_cnt;
        post_check(CHK_PERF);
        end_test("performance counters");
    endtask

    initial begin
        void'($urandom(32'h75778202));
        rst          = 1'b1;
        chk_mask     = '0;
        req_seq      = 0;
        done_seq     = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        test_err_base = 0;
        ref_mcycle   = '0;
        ref_minstret = '0;
        set_idle();
        foreach (dec_opid[i])
            dec_opid[i] = '0;
        csr_mstatus  = '0;
        csr_mtvec    = '0;
        csr_mcause   = '0;
        csr_mepc     = '0;
        cmt_opid     = '0;
        csr_addr     = '0;
        csr_wres     = '0;
        csr_mcycle   = '0;
        csr_minstret = '0;
        dc_addr      = '0;
        dc_wdat      = '0;
        apply_reset();
        test_store_trace();
        test_non_store_resp();
        test_csr_alias();
        test_counter_capture();
        test_snapshot();
        test_perf_counters();
        $display("tests=%0d checks=%0d errors=%0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
